// File: verilog.f
hdl/dbg_pkg.sv
hdl/uart_rx.sv
hdl/uart_word_tx.sv
hdl/debug_dump_sequencer.sv
hdl/debug_subsystem.sv
dv/tb_clock_gen.sv
dv/debug_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module debug_subsystem_tb \
    -f verilog.f \
    -o sim_debug_subsystem

status=0
output=$(./obj_dir/sim_debug_subsystem) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx 'RESULT: PASS'
then
    exit 0
fi

echo "simulation did not pass"
exit 1

// File: dv/debug_subsystem_tb.sv
module debug_subsystem_tb;

    localparam int cpb            = dbg_pkg::clks_per_bit;
    localparam int latch_words    = dbg_pkg::fetch_fields + dbg_pkg::decode_fields
                                    + dbg_pkg::execute_fields + dbg_pkg::memory_fields
                                    + dbg_pkg::wb_fields;
    localparam int dump_words     = 1 + dbg_pkg::num_regs + dbg_pkg::num_mem_words
                                    + latch_words;
    localparam int dump_bytes     = 4 * dump_words;
    localparam int start_timeout  = 40 * cpb;
    localparam int watchdog_limit = 6 * dump_bytes * 10 * cpb + 2000;

    logic                  clk;
    logic                  rst;
    logic                  rx;
    logic                  tx;
    logic                  halt;
    dbg_pkg::core_dbg_rd_t dbg_rd;
    logic [31:0]           core_pc;
    logic [31:0]           core_regs [32];
    logic [31:0]           core_mem [32];
    logic [31:0]           core_latch [128];
    logic [31:0]           reg_rdata;
    logic [31:0]           mem_rdata;
    logic [31:0]           latch_rdata;
    logic [31:0]           expected_words [$];
    int                    field_count [5];
    int                    seed = 2185;
    int                    errors = 0;
    int                    errors_mark = 0;
    int                    checks = 0;
    int                    tests_run = 0;

    tb_clock_gen clock_gen (
        .clk (clk),
        .rst (rst)
    );

    debug_subsystem UUT (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .tx          (tx),
        .halt        (halt),
        .dbg_rd      (dbg_rd),
        .pc          (core_pc),
        .reg_rdata   (reg_rdata),
        .mem_rdata   (mem_rdata),
        .latch_rdata (latch_rdata)
    );

    // Core debug ports answer in the same cycle
    assign reg_rdata   = core_regs[dbg_rd.reg_addr];
    assign mem_rdata   = core_mem[dbg_rd.mem_addr];
    assign latch_rdata = core_latch[{dbg_rd.latch_sel.stage, dbg_rd.latch_sel.field}];

    ////////////////////////////////////////////////////////////////////
    // Core state model
    ////////////////////////////////////////////////////////////////////

    function automatic void load_fixed_state();
        int i;
        core_pc = 32'h0000_1040;
        for (i = 0; i < 32; i++)
        begin
            core_regs[5'(i)] = 32'hA000_0000 + i * 32'h0101_0011;
            core_mem[5'(i)]  = 32'hB000_0000 + i * 32'h0003_0307;
        end
        for (i = 0; i < 128; i++)
            core_latch[7'(i)] = 32'hC0DE_0000 | (i * 32'h0000_0101);
    endfunction

    function automatic void load_random_state();
        int i;
        core_pc = $random(seed);
        for (i = 0; i < 32; i++)
        begin
            core_regs[5'(i)] = $random(seed);
            core_mem[5'(i)]  = $random(seed);
        end
        for (i = 0; i < 128; i++)
            core_latch[7'(i)] = $random(seed);
    endfunction

    // Words in dump order of pc, registers, memory and latch fields by stage
    function automatic void build_expected();
        int s;
        int f;
        expected_words.delete();
        expected_words.push_back(core_pc);
        for (s = 0; s < dbg_pkg::num_regs; s++)
            expected_words.push_back(core_regs[5'(s)]);
        for (s = 0; s < dbg_pkg::num_mem_words; s++)
            expected_words.push_back(core_mem[5'(s)]);
        for (s = 0; s < dbg_pkg::num_stages; s++)
            for (f = 0; f < field_count[s]; f++)
                expected_words.push_back(core_latch[7'(s * 16 + f)]);
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Checks and serial host
    ////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch %s: got 0x%08h expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("%s: done with %0d errors", name, errors - errors_mark);
        errors_mark = errors;
    endtask

    // 8N1 frame on rx with the LSB first
    task automatic send_byte(input logic [7:0] data, input bit bad_stop);
        int i;
        @(negedge clk);
        rx = 1'b0;
        repeat (cpb) @(negedge clk);
        for (i = 0; i < 8; i++)
        begin
            rx = data[i];
            repeat (cpb) @(negedge clk);
        end
        rx = bad_stop ? 1'b0 : 1'b1;
        repeat (cpb) @(negedge clk);
        rx = 1'b1;
    endtask

    // Returns in the middle of the stop bit
    task automatic receive_byte(output logic [7:0] data, output bit halt_at_start,
                                output bit ok);
        int wait_cnt;
        int i;
        wait_cnt = 0;
        data = '0;
        ok = 1'b0;
        halt_at_start = 1'b0;
        do
        begin
            @(negedge clk);
            wait_cnt++;
        end
        while (tx !== 1'b0 && wait_cnt < start_timeout);
        if (tx !== 1'b0)
        begin
            errors++;
            $display("no start bit appeared on tx within %0d cycles", start_timeout);
        end
        else
        begin
            halt_at_start = halt;
            repeat (cpb / 2 - 1) @(negedge clk);
            for (i = 0; i < 8; i++)
            begin
                repeat (cpb) @(negedge clk);
                data[i] = tx;
            end
            repeat (cpb) @(negedge clk);
            ok = (tx === 1'b1);
            if (!ok)
            begin
                errors++;
                $display("stop bit on tx was low");
            end
        end
    endtask

    // Idle means tx high, halt low and no core read address
    task automatic watch_idle(input int cycles, input string tag);
        int  n;
        bit  quiet;
        quiet = 1'b1;
        for (n = 0; n < cycles && quiet; n++)
        begin
            @(negedge clk);
            if (tx !== 1'b1 || halt !== 1'b0 || dbg_rd !== '0)
                quiet = 1'b0;
        end
        check_value({tag, " tx"}, 32'(tx), 32'd1);
        check_value({tag, " halt"}, 32'(halt), 32'd0);
        check_value({tag, " dbg_rd"}, {15'd0, dbg_rd}, 32'd0);
    endtask

    // Decodes one whole dump and waits for halt to drop and the line to stay quiet
    task automatic collect_dump(input string tag);
        logic [7:0]  rx_byte;
        logic [31:0] got;
        bit          halt_at_start;
        bit          ok;
        int          w;
        int          b;
        int          nbytes;
        int          wait_cnt;
        ok = 1'b1;
        nbytes = 0;
        for (w = 0; w < dump_words && ok; w++)
        begin
            got = '0;
            for (b = 0; b < 4 && ok; b++)
            begin
                receive_byte(rx_byte, halt_at_start, ok);
                if (ok)
                begin
                    nbytes++;
                    got = {rx_byte, got[31:8]};
                    check_value({tag, " halt at start bit"}, 32'(halt_at_start), 32'd1);
                end
            end
            if (ok)
                check_value($sformatf("%s word %0d", tag, w), got, expected_words[w]);
        end
        check_value({tag, " byte count"}, nbytes, dump_bytes);
        if (ok)
        begin
            check_value({tag, " halt in last stop bit"}, 32'(halt), 32'd1);
            wait_cnt = 0;
            while (halt !== 1'b0 && wait_cnt < 4 * cpb)
            begin
                @(negedge clk);
                wait_cnt++;
            end
            if (halt !== 1'b0)
            begin
                errors++;
                $display("%s: halt did not fall after the last stop bit", tag);
            end
            watch_idle(30 * cpb, {tag, " after dump"});
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////

    task automatic reset_stays_idle();
        watch_idle(200, "reset idle");
        report_test("reset idle");
    endtask

    task automatic dump_fixed_state();
        load_fixed_state();
        build_expected();
        fork
            send_byte(dbg_pkg::cmd_dump, 1'b0);
            collect_dump("fixed dump");
        join
        report_test("fixed dump and halt window");
    endtask

    task automatic reject_bad_bytes();
        fork
            send_byte(8'h55, 1'b0);
            watch_idle(40 * cpb, "other byte");
        join
        fork
            send_byte(dbg_pkg::cmd_dump, 1'b1);
            watch_idle(40 * cpb, "bad stop bit");
        join
        report_test("rejected bytes");
    endtask

    task automatic dump_ignores_second_cmd();
        load_random_state();
        build_expected();
        fork
            begin
                send_byte(dbg_pkg::cmd_dump, 1'b0);
                repeat (dump_bytes * 10 * cpb / 3) @(negedge clk);
                send_byte(dbg_pkg::cmd_dump, 1'b0);
            end
            collect_dump("random dump");
        join
        report_test("random dump with extra command");
    endtask

    task automatic dump_twice();
        int n;
        for (n = 0; n < 2; n++)
        begin
            load_random_state();
            build_expected();
            fork
                send_byte(dbg_pkg::cmd_dump, 1'b0);
                collect_dump($sformatf("dump %0d", n + 1));
            join
        end
        report_test("two consecutive dumps");
    endtask

    initial
    begin
        field_count[0] = dbg_pkg::fetch_fields;
        field_count[1] = dbg_pkg::decode_fields;
        field_count[2] = dbg_pkg::execute_fields;
        field_count[3] = dbg_pkg::memory_fields;
        field_count[4] = dbg_pkg::wb_fields;
        rx = 1'b1;
        load_fixed_state();
        wait (rst == 1'b0);
        @(negedge clk);
        reset_stays_idle();
        dump_fixed_state();
        reject_bad_bytes();
        dump_ignores_second_cmd();
        dump_twice();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // Six dumps of serial time plus margin
    initial
    begin
        repeat (watchdog_limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_limit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: dv/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int period     = 100;
    localparam int rst_cycles = 4;

    initial
    begin
        clk = 1'b0;
        forever
            #(period / 2) clk = ~clk;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial
    begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: hdl/debug_subsystem.sv
module debug_subsystem (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rx,
    output logic                  tx,
    output logic                  halt,
    output dbg_pkg::core_dbg_rd_t dbg_rd,
    input  logic [31:0]           pc,
    input  logic [31:0]           reg_rdata,
    input  logic [31:0]           mem_rdata,
    input  logic [31:0]           latch_rdata
);

    // Receiver to sequencer
    logic [7:0]  rx_data;
    logic        rx_valid;

    // Sequencer to transmitter handshake
    logic [31:0] word;
    logic        word_req;
    logic        word_ack;

    uart_rx u_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    debug_dump_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .pc          (pc),
        .reg_rdata   (reg_rdata),
        .mem_rdata   (mem_rdata),
        .latch_rdata (latch_rdata),
        .dbg_rd      (dbg_rd),
        .halt        (halt),
        .word        (word),
        .word_req    (word_req),
        .word_ack    (word_ack)
    );

    uart_word_tx u_uart_word_tx (
        .clk      (clk),
        .rst      (rst),
        .word     (word),
        .word_req (word_req),
        .word_ack (word_ack),
        .tx       (tx)
    );

endmodule

// File: hdl/debug_dump_sequencer.sv
module debug_dump_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            rx_data,
    input  logic                  rx_valid,
    input  logic [31:0]           pc,
    input  logic [31:0]           reg_rdata,
    input  logic [31:0]           mem_rdata,
    input  logic [31:0]           latch_rdata,
    output dbg_pkg::core_dbg_rd_t dbg_rd,
    output logic                  halt,
    output logic [31:0]           word,
    output logic                  word_req,
    input  logic                  word_ack
);

    typedef enum logic [1:0] {
        hs_issue,
        hs_wait_ack,
        hs_wait_low
    } hs_phase_e;

    dbg_pkg::dump_section_e section;
    hs_phase_e              phase;
    logic [4:0]             idx;
    dbg_pkg::latch_sel_t    latch_sel;
    logic [31:0]            core_word;
    logic                   field_last;
    logic                   section_last;
    logic                   issue;

    //////////////////////////////////////////////////////////////////////
    // Core read selection
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        dbg_rd.reg_addr  = (section == dbg_pkg::regs) ? idx : 5'd0;
        dbg_rd.mem_addr  = (section == dbg_pkg::mem) ? idx : 5'd0;
        dbg_rd.latch_sel = latch_sel;
    end

    always_comb
    begin
        case (section)
            dbg_pkg::pc:    core_word = pc;
            dbg_pkg::regs:  core_word = reg_rdata;
            dbg_pkg::mem:   core_word = mem_rdata;
            dbg_pkg::latch: core_word = latch_rdata;
            default:        core_word = 32'd0;
        endcase
    end

    assign field_last =
        (latch_sel.field == dbg_pkg::stage_fields(latch_sel.stage) - 4'd1);

    always_comb
    begin
        case (section)
            dbg_pkg::pc:    section_last = 1'b1;
            dbg_pkg::regs:  section_last = (idx == dbg_pkg::reg_last);
            dbg_pkg::mem:   section_last = (idx == dbg_pkg::mem_last);
            dbg_pkg::latch: section_last = field_last &&
                                           (latch_sel.stage == dbg_pkg::stage_last);
            default:        section_last = 1'b0;
        endcase
    end

    assign issue = (phase == hs_issue) && (section != dbg_pkg::idle)
                   && (section != dbg_pkg::finish);

    //////////////////////////////////////////////////////////////////////
    // Section walk and handshake
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            section   <= dbg_pkg::idle;
            phase     <= hs_issue;
            idx       <= '0;
            latch_sel <= '0;
            halt      <= 1'b0;
            word_req  <= 1'b0;
        end
        else
        begin
            case (section)
                dbg_pkg::idle:
                begin
                    if (rx_valid && rx_data == dbg_pkg::cmd_dump)
                    begin
                        halt    <= 1'b1;
                        phase   <= hs_issue;
                        section <= dbg_pkg::pc;
                    end
                end
                dbg_pkg::finish:
                begin
                    idx       <= '0;
                    latch_sel <= '0;
                    section   <= dbg_pkg::idle;
                end
                default:
                begin
                    case (phase)
                        hs_issue:
                        begin
                            word_req <= 1'b1;
                            phase    <= hs_wait_ack;
                        end
                        hs_wait_ack:
                        begin
                            if (word_ack)
                            begin
                                word_req <= 1'b0;
                                phase    <= hs_wait_low;
                            end
                        end
                        default:
                        begin
                            if (!word_ack)
                            begin
                                phase <= hs_issue;
                                if (section_last)
                                begin
                                    idx <= '0;
                                    case (section)
                                        dbg_pkg::pc:   section <= dbg_pkg::regs;
                                        dbg_pkg::regs: section <= dbg_pkg::mem;
                                        dbg_pkg::mem:  section <= dbg_pkg::latch;
                                        default:
                                        begin
                                            // Last word out, release the core
                                            halt    <= 1'b0;
                                            section <= dbg_pkg::finish;
                                        end
                                    endcase
                                end
                                else if (section == dbg_pkg::latch)
                                begin
                                    if (field_last)
                                    begin
                                        latch_sel.stage <= latch_sel.stage + 3'd1;
                                        latch_sel.field <= 4'd0;
                                    end
                                    else
                                        latch_sel.field <= latch_sel.field + 4'd1;
                                end
                                else
                                    idx <= idx + 5'd1;
                            end
                        end
                    endcase
                end
            endcase
        end
    end

    // Sampled in the cycle req rises
    always_ff @(posedge clk)
    begin
        if (issue)
            word <= core_word;
    end

    req_held_for_ack: assert property (
        @(posedge clk) disable iff (rst) $fell(word_req) |-> $past(word_ack));

    word_stable_in_req: assert property (
        @(posedge clk) disable iff (rst)
        (word_req && $past(word_req)) |-> $stable(word));

endmodule

// File: hdl/uart_word_tx.sv
module uart_word_tx (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] word,
    input  logic        word_req,
    output logic        word_ack,
    output logic        tx
);

    typedef enum logic [1:0] {
        st_idle,
        st_send,
        st_ack
    } tx_state_e;

    tx_state_e                        state;
    logic [dbg_pkg::word_width-1:0]   shift;
    logic [1:0]                       byte_cnt;
    logic [3:0]                       bit_cnt;
    logic [dbg_pkg::baud_w-1:0]       baud_cnt;

    //////////////////////////////////////////////////////////////////////
    // Frame engine
    //////////////////////////////////////////////////////////////////////

    // bit_cnt counts the bit now on the line: 0 start, 1..8 data, 9 stop
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= st_idle;
            byte_cnt <= '0;
            bit_cnt  <= '0;
            baud_cnt <= '0;
            word_ack <= 1'b0;
            tx       <= 1'b1;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (word_req)
                    begin
                        tx       <= 1'b0;
                        byte_cnt <= '0;
                        bit_cnt  <= '0;
                        baud_cnt <= '0;
                        state    <= st_send;
                    end
                end
                st_send:
                begin
                    baud_cnt <= baud_cnt + 1'b1;
                    if (baud_cnt == dbg_pkg::baud_last)
                    begin
                        baud_cnt <= '0;
                        if (bit_cnt == 4'd9)
                        begin
                            if (byte_cnt == 2'd3)
                            begin
                                word_ack <= 1'b1;
                                state    <= st_ack;
                            end
                            else
                            begin
                                // Next start bit straight after the stop bit
                                tx       <= 1'b0;
                                bit_cnt  <= '0;
                                byte_cnt <= byte_cnt + 1'b1;
                            end
                        end
                        else
                        begin
                            tx      <= (bit_cnt == 4'd8) ? 1'b1 : shift[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default:
                begin
                    if (!word_req)
                    begin
                        word_ack <= 1'b0;
                        state    <= st_idle;
                    end
                end
            endcase
        end
    end

    // Shift copy of the word, one place per data bit sent
    always_ff @(posedge clk)
    begin
        if (state == st_idle && word_req)
            shift <= word;
        else if (state == st_send && baud_cnt == dbg_pkg::baud_last
                 && bit_cnt != 4'd8 && bit_cnt != 4'd9)
            shift <= shift >> 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    ack_only_on_req: assert property (
        @(posedge clk) disable iff (rst) $rose(word_ack) |-> word_req);

    line_idle_high: assert property (
        @(posedge clk) disable iff (rst) (state == st_idle) |-> tx);

endmodule

// File: hdl/uart_rx.sv
module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_stop,
        st_recover
    } rx_state_e;

    rx_state_e                   state;
    logic                        rx_meta;
    logic                        rx_sync;
    logic                        rx_prev;
    logic                        start_edge;
    logic                        bit_tick;
    logic [dbg_pkg::baud_w-1:0]  baud_cnt;
    logic [2:0]                  bit_cnt;

    // Two-flop synchroniser, third flop only for the edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev & ~rx_sync;
    assign bit_tick   = (baud_cnt == dbg_pkg::baud_last);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= st_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                st_idle:
                begin
                    baud_cnt <= '0;
                    if (start_edge)
                        state <= st_start;
                end
                st_start:
                begin
                    // Glitch check at the middle of the start bit
                    if (baud_cnt == dbg_pkg::half_last)
                    begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? st_idle : st_data;
                    end
                end
                st_data:
                begin
                    if (bit_tick)
                    begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= st_stop;
                    end
                end
                st_stop:
                begin
                    if (bit_tick)
                    begin
                        baud_cnt <= '0;
                        rx_valid <= rx_sync;
                        state    <= rx_sync ? st_idle : st_recover;
                    end
                end
                default:
                begin
                    // Framing error, wait for the line to go idle
                    baud_cnt <= '0;
                    if (rx_sync)
                        state <= st_idle;
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk)
    begin
        if (state == st_data && bit_tick)
            rx_data <= {rx_sync, rx_data[7:1]};
    end

endmodule

// File: hdl/dbg_pkg.sv
package dbg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Serial timing
    //////////////////////////////////////////////////////////////////////

    localparam int clks_per_bit = 8;
    localparam int baud_w       = $clog2(clks_per_bit);

    // Last count of a full bit and of half a bit
    localparam logic [baud_w-1:0] baud_last = baud_w'(clks_per_bit - 1);
    localparam logic [baud_w-1:0] half_last = baud_w'(clks_per_bit / 2 - 1);

    //////////////////////////////////////////////////////////////////////
    // Dump layout
    //////////////////////////////////////////////////////////////////////

    localparam int          num_regs      = 32;
    localparam int          num_mem_words = 20;
    localparam int          word_width    = 32;
    localparam logic [7:0]  cmd_dump      = 8'h44;

    localparam logic [4:0]  reg_last = 5'(num_regs - 1);
    localparam logic [4:0]  mem_last = 5'(num_mem_words - 1);

    // Fields per pipeline latch
    localparam int fetch_fields   = 2;
    localparam int decode_fields  = 6;
    localparam int execute_fields = 6;
    localparam int memory_fields  = 5;
    localparam int wb_fields      = 2;
    localparam int num_stages     = 5;

    localparam logic [2:0] stage_last = 3'(num_stages - 1);

    typedef enum logic [2:0] {
        idle,
        pc,
        regs,
        mem,
        latch,
        finish
    } dump_section_e;

    typedef struct packed {
        logic [2:0] stage;
        logic [3:0] field;
    } latch_sel_t;

    typedef struct packed {
        logic [4:0] reg_addr;
        logic [4:0] mem_addr;
        latch_sel_t latch_sel;
    } core_dbg_rd_t;

    // Number of fields held by one stage latch
    function automatic logic [3:0] stage_fields(input logic [2:0] stage);
        logic [3:0] n;
        case (stage)
            3'd0:    n = 4'(fetch_fields);
            3'd1:    n = 4'(decode_fields);
            3'd2:    n = 4'(execute_fields);
            3'd3:    n = 4'(memory_fields);
            3'd4:    n = 4'(wb_fields);
            default: n = 4'd1;
        endcase
        return n;
    endfunction

endpackage
